//--- all.f
design/mxu_pkg.sv
design/mxu_mac.sv
design/mxu_skew.sv
design/mxu_array.sv
design/mxu_drain.sv
design/mxu_apb_regs.sv
design/mxu_top.sv
test/mxu_properties.sv
test/mxu_tb.sv

//--- design/mxu_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module mxu_apb_regs
    import mxu_pkg::*;
#(
    parameter int dim       = DIM_MAX,
    parameter int res_depth = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output pipe_vec_t   launch,
    output weight_mat_t weights,
    input  res_vec_t    result
);

    localparam int cnt_w = $clog2(res_depth + 1);                  // holds 0..res_depth
    localparam int ptr_w = (res_depth > 1) ? $clog2(res_depth) : 1;

    logic             access;                 // apb access phase
    logic             is_status, is_weight, is_vec, is_res;
    logic [1:0]       idx;                    // weight row or result column
    logic             err, stall, done;
    logic             vec_fire, wgt_fire, pop;
    logic             credit_full, fifo_empty;
    logic [cnt_w-1:0] inflight_q, level_q;
    logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
    weight_mat_t      weight_q;
    sum_vec_t         fifo_mem [res_depth];
    sum_vec_t         head;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(res_depth - 1)) begin
            return '0;   // circular wrap
        end
        return p + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // decode and handshake
    ////////////////////////////////////////////////////////////
    assign access    = psel & penable;
    assign idx       = paddr[3:2];
    assign is_status = paddr == REG_STATUS;
    assign is_weight = ((paddr & 8'hf3) == REG_WEIGHT0) && (int'(idx) < dim); // rows past dim unmapped
    assign is_vec    = paddr == REG_VEC;
    assign is_res    = (paddr & 8'hf3) == REG_RES0;

    assign fifo_empty  = level_q == '0;
    assign credit_full = int'(inflight_q) + int'(level_q) >= res_depth;

    assign err = !(is_status | is_weight | is_vec | is_res)   // hole in the map
               | (pwrite & (is_status | is_res))              // read-only target
               | (!pwrite & is_vec)                           // vec is write only
               | (!pwrite & is_res & fifo_empty);             // nothing to return

    // hold the bus until a credit frees, or until old vectors are through the array
    assign stall = pwrite & ((is_vec & credit_full) | (is_weight & (inflight_q != '0)));

    assign pready   = access & !stall;
    assign pslverr  = pready & err;
    assign done     = pready & !err;        // errored accesses change nothing
    assign vec_fire = done & pwrite & is_vec;
    assign wgt_fire = done & pwrite & is_weight;
    assign pop      = done & !pwrite & (paddr == REG_RES3);

    assign launch = '{valid: vec_fire, data: pwdata};   // skew stage registers it

    ////////////////////////////////////////////////////////////
    // weights and counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            weight_q <= '0;
        end else if (wgt_fire) begin
            weight_q[idx] <= pwdata;
        end
    end

    assign weights = weight_q;   // steady while anything is in flight

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inflight_q <= '0;
            level_q    <= '0;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
        end else begin
            // a result leaves the pipe and enters the fifo on the same edge
            inflight_q <= inflight_q + cnt_w'(vec_fire) - cnt_w'(result.valid);
            level_q    <= level_q + cnt_w'(result.valid) - cnt_w'(pop);
            if (result.valid) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
        end
    end

    // result storage, never full on a push thanks to the credit rule
    always_ff @(posedge clk) begin
        if (result.valid) begin
            fifo_mem[wr_ptr_q] <= result.sum;
        end
    end

    assign head = fifo_mem[rd_ptr_q];

    ////////////////////////////////////////////////////////////
    // read data
    ////////////////////////////////////////////////////////////
    always_comb begin
        prdata = '0;
        if (!pwrite) begin
            if (is_status) begin
                prdata[7:0]  = 8'(inflight_q);
                prdata[15:8] = 8'(level_q);
            end else if (is_weight) begin
                prdata = weight_q[idx];
            end else if (is_res & !fifo_empty) begin
                prdata = 32'(signed'(head[idx]));   // sign-extend the column
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mxu_array.sv
`timescale 1ns/100ps
`default_nettype none

module mxu_array
    import mxu_pkg::*;
#(
    parameter int dim = DIM_MAX
) (
    input  logic           clk,
    input  logic           arst_n,
    input  vec_t           row_data,
    input  logic [dim-1:0] row_valid,
    input  weight_mat_t    weights,
    output sum_vec_t       col_sum,
    output logic [dim-1:0] col_valid
);

    data_t x_link [dim][dim+1];   // x moving right, last index is the far edge
    acc_t  s_link [dim+1][dim];   // sums moving down, row 0 is the zero feed

    logic [dim-1:0] x_v  [dim];   // valid of x leaving each cell
    logic [dim-1:0] s_v  [dim];   // valid of sum leaving each cell
    logic [dim-1:0] x_at [dim];   // valid of x arriving at each cell
    logic [dim-1:0] s_at [dim];   // valid of sum arriving from above

    ////////////////////////////////////////////////////////////
    // cell grid
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < dim; i++) begin : g_row
        assign x_link[i][0] = row_data[i];
        for (genvar j = 0; j < dim; j++) begin : g_col
            if (i == 0) begin : g_top
                assign s_link[0][j] = '0;   // top row starts from zero
            end
            mxu_mac u_mac (
                .clk      (clk),
                .arst_n   (arst_n),
                .data_in  (x_link[i][j]),
                .weight   (weights[i][j]),
                .sum_in   (s_link[i][j]),
                .sum_out  (s_link[i+1][j]),
                .data_out (x_link[i][j+1])
            );
        end
    end

    // valid bits shadow the cells so each column knows when its sum is whole
    always_comb begin
        s_at[0] = '1;
        for (int i = 0; i < dim; i++) begin
            x_at[i] = dim'({x_v[i], row_valid[i]});   // shift in from the row edge
        end
        for (int i = 1; i < dim; i++) begin
            s_at[i] = s_v[i-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < dim; i++) begin
                x_v[i] <= '0;
                s_v[i] <= '0;
            end
        end else begin
            for (int i = 0; i < dim; i++) begin
                x_v[i] <= x_at[i];
                s_v[i] <= x_at[i] & s_at[i];   // every row has added its term
            end
        end
    end

    for (genvar j = 0; j < DIM_MAX; j++) begin : g_out
        if (j < dim) begin : g_used
            assign col_sum[j] = s_link[dim][j];
        end else begin : g_unused
            assign col_sum[j] = '0;
        end
    end

    assign col_valid = s_v[dim-1];   // bottom row, column j one cycle after j-1

endmodule

`default_nettype wire

//--- design/mxu_drain.sv
`timescale 1ns/100ps
`default_nettype none

module mxu_drain
    import mxu_pkg::*;
#(
    parameter int dim = DIM_MAX
) (
    input  logic           clk,
    input  logic           arst_n,
    input  sum_vec_t       col_sum,
    input  logic [dim-1:0] col_valid,
    output res_vec_t       result
);

    sum_vec_t       aligned_sum;   // all columns in the same cycle
    logic [dim-1:0] aligned_v;
    logic           res_v_q;
    sum_vec_t       res_sum_q;

    // column j arrives j cycles after column 0, so it waits dim-1-j cycles
    for (genvar j = 0; j < DIM_MAX; j++) begin : g_col
        if (j >= dim) begin : g_unused
            assign aligned_sum[j] = '0;
        end else if (j == dim - 1) begin : g_direct
            assign aligned_sum[j] = col_sum[j];   // latest column, no wait
            assign aligned_v[j]   = col_valid[j];
        end else begin : g_delay
            localparam int n = dim - 1 - j;
            acc_t         tap_s [n];
            logic [n-1:0] tap_v;

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    tap_v <= '0;
                end else begin
                    tap_v[0] <= col_valid[j];
                    for (int k = 1; k < n; k++) begin
                        tap_v[k] <= tap_v[k-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                tap_s[0] <= col_sum[j];
                for (int k = 1; k < n; k++) begin
                    tap_s[k] <= tap_s[k-1];
                end
            end

            assign aligned_sum[j] = tap_s[n-1];
            assign aligned_v[j]   = tap_v[n-1];
        end
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_v_q <= 1'b0;
        end else begin
            res_v_q <= &aligned_v;   // column 0 is last to line up
        end
    end

    always_ff @(posedge clk) begin
        res_sum_q <= aligned_sum;
    end

    assign result = '{valid: res_v_q, sum: res_sum_q};

endmodule

`default_nettype wire

//--- design/mxu_mac.sv
`timescale 1ns/100ps
`default_nettype none

module mxu_mac
    import mxu_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  data_t data_in,    // x from the left
    input  data_t weight,     // stationary w[i][j]
    input  acc_t  sum_in,     // partial sum from above
    output acc_t  sum_out,    // partial sum going down
    output data_t data_out    // x going right
);

    logic signed [2*DATA_W-1:0] product;   // full precision, -128 * -128 still fits

    // both operands widened with their sign before the multiply
    assign product = (2*DATA_W)'(signed'(data_in)) * (2*DATA_W)'(signed'(weight));

    ////////////////////////////////////////////////////////////
    // one register stage for both paths
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_out  <= '0;
            data_out <= '0;
        end else begin
            sum_out  <= sum_in + ACC_W'(product);   // sign-extended product
            data_out <= data_in;                    // neighbour sees x next cycle
        end
    end

endmodule

`default_nettype wire

//--- design/mxu_pkg.sv
`default_nettype none

package mxu_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    localparam int DATA_W  = 8;                              // signed operand
    localparam int DIM_MAX = 4;                              // largest array side
    localparam int ACC_W   = 2 * DATA_W + $clog2(DIM_MAX);   // room for DIM_MAX products

    typedef logic [DATA_W-1:0] data_t;   // one operand, two's complement
    typedef logic [ACC_W-1:0]  acc_t;    // partial or final column sum

    // element i sits in byte i, same layout as the VEC register
    typedef data_t [DIM_MAX-1:0] vec_t;
    typedef acc_t  [DIM_MAX-1:0] sum_vec_t;

    // row i holds w[i][0..DIM-1]
    typedef vec_t [DIM_MAX-1:0] weight_mat_t;

    ////////////////////////////////////////////////////////////
    // pipeline payloads
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic valid;      // one-cycle launch strobe
        vec_t data;
    } pipe_vec_t;

    typedef struct packed {
        logic     valid;  // aligned result, pushed into the fifo
        sum_vec_t sum;
    } res_vec_t;

    ////////////////////////////////////////////////////////////
    // apb register map
    ////////////////////////////////////////////////////////////
    typedef logic [7:0] apb_addr_t;

    localparam apb_addr_t REG_STATUS  = 8'h00;   // ro, level and in-flight count
    localparam apb_addr_t REG_WEIGHT0 = 8'h10;   // rw weight rows
    localparam apb_addr_t REG_WEIGHT1 = 8'h14;
    localparam apb_addr_t REG_WEIGHT2 = 8'h18;
    localparam apb_addr_t REG_WEIGHT3 = 8'h1C;
    localparam apb_addr_t REG_VEC     = 8'h20;   // wo, each write launches
    localparam apb_addr_t REG_RES0    = 8'h30;   // ro result columns
    localparam apb_addr_t REG_RES1    = 8'h34;
    localparam apb_addr_t REG_RES2    = 8'h38;
    localparam apb_addr_t REG_RES3    = 8'h3C;   // read pops the head

endpackage

`default_nettype wire

//--- design/mxu_skew.sv
`timescale 1ns/100ps
`default_nettype none

module mxu_skew
    import mxu_pkg::*;
#(
    parameter int dim = DIM_MAX
) (
    input  logic           clk,
    input  logic           arst_n,
    input  pipe_vec_t      launch,
    output vec_t           row_data,
    output logic [dim-1:0] row_valid
);

    logic in_v_q;   // input register, valid part
    vec_t in_d_q;   // input register, data part

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_v_q <= 1'b0;
        end else begin
            in_v_q <= launch.valid;
        end
    end

    always_ff @(posedge clk) begin
        in_d_q <= launch.data;
    end

    // row i gets i extra taps so the vector enters the array on a diagonal
    for (genvar i = 0; i < DIM_MAX; i++) begin : g_row
        if (i >= dim) begin : g_unused
            assign row_data[i] = '0;
        end else if (i == 0) begin : g_first
            assign row_data[0]  = in_d_q[0];   // no extra delay
            assign row_valid[0] = in_v_q;
        end else begin : g_delay
            data_t        tap_d [i];
            logic [i-1:0] tap_v;

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    tap_v <= '0;
                end else begin
                    tap_v[0] <= in_v_q;
                    for (int k = 1; k < i; k++) begin
                        tap_v[k] <= tap_v[k-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                tap_d[0] <= in_d_q[i];
                for (int k = 1; k < i; k++) begin
                    tap_d[k] <= tap_d[k-1];
                end
            end

            assign row_data[i]  = tap_d[i-1];   // last tap of the row
            assign row_valid[i] = tap_v[i-1];
        end
    end

endmodule

`default_nettype wire

//--- design/mxu_top.sv
`timescale 1ns/100ps
`default_nettype none

module mxu_top
    import mxu_pkg::*;
#(
    parameter int dim       = DIM_MAX,   // array side, at most DIM_MAX
    parameter int res_depth = 4          // result fifo entries
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    pipe_vec_t      launch;      // apb to skew
    weight_mat_t    weights;     // apb to array, steady
    vec_t           row_data;    // skew to array
    logic [dim-1:0] row_valid;
    sum_vec_t       col_sum;     // array to drain
    logic [dim-1:0] col_valid;
    res_vec_t       result;      // drain back to the fifo

    mxu_apb_regs #(.dim(dim), .res_depth(res_depth)) u_regs (
        .clk, .arst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .launch, .weights, .result
    );

    mxu_skew #(.dim(dim)) u_skew (
        .clk, .arst_n,
        .launch, .row_data, .row_valid
    );

    mxu_array #(.dim(dim)) u_array (
        .clk, .arst_n,
        .row_data, .row_valid, .weights,
        .col_sum, .col_valid
    );

    mxu_drain #(.dim(dim)) u_drain (
        .clk, .arst_n,
        .col_sum, .col_valid, .result
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the mxu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module mxu_tb -o mxu_sim

./obj_dir/mxu_sim > sim.log 2>&1 || { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"

//--- test/mxu_properties.sv
`timescale 1ns/100ps
`default_nettype none

module mxu_properties #(
    parameter int res_depth = 4
) (
    input logic       clk,
    input logic       arst_n,
    input logic       psel,
    input logic       penable,
    input logic [7:0] inflight,       // vectors launched but not yet in the fifo
    input logic [7:0] level,          // results stored
    input logic       result_valid    // drain pushes this cycle
);

    int fail_count = 0;   // failed assertions so far

    ////////////////////////////////////////////////////////////
    // apb protocol
    ////////////////////////////////////////////////////////////
    // access phase only after a setup cycle with psel high
    a_setup_first: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(penable) |-> psel && $past(psel))
        else begin
            fail_count++;
            $error("penable rose without a psel setup cycle");
        end

    ////////////////////////////////////////////////////////////
    // credit and fifo
    ////////////////////////////////////////////////////////////
    a_credit: assert property (@(posedge clk) disable iff (!arst_n)
        int'(inflight) + int'(level) <= res_depth)
        else begin
            fail_count++;
            $error("in-flight count plus FIFO level above res_depth");
        end

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid |-> int'(level) < res_depth)   // push into a full fifo
        else begin
            fail_count++;
            $error("result arrived while the FIFO was full");
        end

endmodule

`default_nettype wire

//--- test/mxu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mxu_tb
    import mxu_pkg::*;
();

    localparam int          array_dim   = 4;
    localparam int          fifo_depth  = 4;
    localparam int          cycle_limit = 20000;   // ~450 accesses of a few cycles each
    localparam logic [31:0] rand_seed   = 32'h9508a3c5;

    // corner cases where every weight row gets ext_w[k]
    localparam logic [31:0] ext_w [4] = '{32'h80808080, 32'h7f7f7f7f, 32'h7f807f80, 32'h01ff807f};
    localparam logic [31:0] ext_x [4] = '{32'h80808080, 32'h80808080, 32'h807f807f, 32'hff80017f};

    logic        clk;
    logic        arst_n;
    logic        psel, penable, pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;

    int           errors = 0;
    int           cycles = 0;
    logic [31:0]  w_model [array_dim];   // byte j of row i is w[i][j]
    logic [127:0] exp_q [$];             // expected columns of 32 bits each in launch order

    mxu_top #(.dim(array_dim), .res_depth(fifo_depth)) DUT (
        .clk, .arst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    bind mxu_top mxu_properties #(.res_depth(res_depth)) u_props (
        .clk, .arst_n, .psel, .penable,
        .inflight     (8'(u_regs.inflight_q)),
        .level        (8'(u_regs.level_q)),
        .result_valid (result.valid)
    );

    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [127:0] model_result(input logic [31:0] vec);
        logic [127:0] res;
        int           acc;
        res = '0;
        for (int j = 0; j < array_dim; j++) begin
            acc = 0;   // column j = sum over rows of x_i * w[i][j]
            for (int i = 0; i < array_dim; i++) begin
                acc += int'($signed(vec[8*i +: 8])) * int'($signed(w_model[i][8*j +: 8]));
            end
            res[32*j +: 32] = acc;   // sign-extended to 32 bits
        end
        return res;
    endfunction

    function automatic apb_addr_t weight_addr(input int row);
        return REG_WEIGHT0 + apb_addr_t'(4 * row);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // apb access driven on posedge and sampled at negedge
    ////////////////////////////////////////////////////////////
    task automatic apb_access(input logic wr, input apb_addr_t addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err, output int waits);
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;      // setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;      // access phase
        @(negedge clk);
        while (!pready) begin
            waits++;          // stretched by the slave
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);       // completing edge
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_ok(input apb_addr_t addr, output logic [31:0] data);
        logic err;
        int   waits;
        apb_access(1'b0, addr, '0, data, err, waits);
        if (err) begin
            errors++;
            $display("read of address %h returned pslverr", addr);
        end
    endtask

    task automatic write_weight(input int row, input logic [31:0] data, output int waits);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, weight_addr(row), data, rd, err, waits);
        if (err) begin
            errors++;
            $display("write of weight row %0d returned pslverr", row);
        end else begin
            w_model[row] = data;
        end
    endtask

    task automatic load_random_weights();
        int waits;
        for (int r = 0; r < array_dim; r++) begin
            write_weight(r, $urandom(), waits);
        end
    endtask

    task automatic launch_vec(input logic [31:0] vec);
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_access(1'b1, REG_VEC, vec, rd, err, waits);
        if (err) begin
            errors++;
            $display("VEC write of %h returned pslverr", vec);
        end else begin
            exp_q.push_back(model_result(vec));   // weights as of completion
        end
    endtask

    // poll STATUS until the fifo holds at least target results
    task automatic wait_level(input int target);
        logic [31:0] st;
        st = '0;
        while (int'(st[15:8]) < target) begin
            read_ok(REG_STATUS, st);
            if (int'(st[7:0]) + int'(st[15:8]) > fifo_depth) begin
                errors++;
                $display("STATUS shows %0d in flight and %0d stored, more than the FIFO holds",
                         st[7:0], st[15:8]);
            end
        end
    endtask

    task automatic read_result();
        logic [127:0] exp;
        logic [31:0]  rd;
        wait_level(1);
        if (exp_q.size() == 0) begin
            errors++;
            $display("a result is waiting in the FIFO but no vector was expected");
        end else begin
            exp = exp_q.pop_front();
            for (int c = 0; c < array_dim; c++) begin   // RES3 read pops
                read_ok(REG_RES0 + apb_addr_t'(4 * c), rd);
                check_value($sformatf("prdata from RES%0d", c), rd, exp[32*c +: 32]);
            end
        end
    endtask

    task automatic check_status(input logic [7:0] inflight, input logic [7:0] level);
        logic [31:0] rd;
        read_ok(REG_STATUS, rd);
        check_value("prdata from STATUS", rd, {16'h0, level, inflight});
    endtask

    task automatic check_weights();
        logic [31:0] rd;
        for (int r = 0; r < array_dim; r++) begin
            read_ok(weight_addr(r), rd);
            check_value($sformatf("prdata from WEIGHT%0d", r), rd, w_model[r]);
        end
    endtask

    task automatic expect_error(input logic wr, input apb_addr_t addr, input string what);
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_access(wr, addr, 32'hffffffff, rd, err, waits);
        if (!err) begin
            errors++;
            $display("%s completed without pslverr", what);
        end
    endtask

    // vec write with no credit must stay stretched until the access is withdrawn
    task automatic probe_vec_stall(input logic [31:0] vec, input int hold_cycles);
        int held;
        held = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= REG_VEC;
        pwdata  <= vec;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && held < hold_cycles) begin
            held++;
            @(negedge clk);
        end
        if (pready) begin
            errors++;
            $display("VEC write accepted with no free credit after %0d wait cycles", held);
            exp_q.push_back(model_result(vec));   // keep the model in step
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int          waits;
        int          row;
        logic [31:0] rd;
        logic [31:0] data;

        clk     = 1'b0;
        arst_n  <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        for (int r = 0; r < array_dim; r++) begin
            w_model[r] = '0;
        end
        void'($urandom(rand_seed));
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // reset state and weight read back
        check_status(8'd0, 8'd0);
        check_weights();
        for (int n = 0; n < 20; n++) begin
            row  = $urandom_range(array_dim - 1, 0);
            data = $urandom();
            write_weight(row, data, waits);
            read_ok(weight_addr(row), rd);
            check_value($sformatf("prdata from WEIGHT%0d", row), rd, data);
        end

        // random vectors with weights reloaded every 8
        for (int n = 0; n < 40; n++) begin
            if (n % 8 == 0) begin
                load_random_weights();
            end
            launch_vec($urandom());
            read_result();
        end
        for (int k = 0; k < 4; k++) begin   // -128 * -128 and friends
            for (int r = 0; r < array_dim; r++) begin
                write_weight(r, ext_w[k], waits);
            end
            launch_vec(ext_x[k]);
            read_result();
        end

        // back-pressure with the credit full after four launches
        load_random_weights();
        for (int n = 0; n < fifo_depth; n++) begin
            launch_vec($urandom());
        end
        wait_level(fifo_depth);
        probe_vec_stall($urandom(), 40);
        check_status(8'd0, 8'(fifo_depth));
        read_result();
        read_result();
        launch_vec($urandom());
        launch_vec($urandom());
        repeat (fifo_depth) read_result();

        // weight write waits for vectors in flight
        load_random_weights();
        launch_vec($urandom());
        launch_vec($urandom());
        row  = $urandom_range(array_dim - 1, 0);
        data = $urandom();
        write_weight(row, data, waits);
        if (waits == 0) begin
            errors++;
            $display("WEIGHT write with vectors in flight was not stretched");
        end
        launch_vec($urandom());
        repeat (3) read_result();

        // error responses change no state
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results were never read", exp_q.size());
        end
        check_status(8'd0, 8'd0);
        expect_error(1'b0, REG_RES0, "RES0 read with an empty FIFO");
        expect_error(1'b0, REG_RES3, "RES3 read with an empty FIFO");
        expect_error(1'b0, REG_VEC, "VEC read");
        expect_error(1'b1, REG_STATUS, "STATUS write");
        expect_error(1'b1, REG_RES0, "RES0 write");
        expect_error(1'b0, 8'h44, "read of unmapped address 44");
        expect_error(1'b1, 8'h04, "write to unmapped address 04");
        check_status(8'd0, 8'd0);
        check_weights();

        $display("run complete with %0d check errors and %0d assertion failures",
                 errors, DUT.u_props.fail_count);
        if (errors == 0 && DUT.u_props.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
